//--- icache_lce.f
logic/icache_lce_pkg.sv
logic/lce_init_sweep.sv
logic/lce_cmd_fsm.sv
logic/icache_lce.sv
testbench/lce_checker.sv
testbench/tb_icache_lce.sv

//--- logic/icache_lce.sv
//############################
// icache LCE command side, sweep first and then directory commands
//############################

module icache_lce (
  input  logic                                    clk_i,
  input  logic                                    reset_i,
  input  logic [icache_lce_pkg::lce_id_width-1:0] lce_id_i,
  input  icache_lce_pkg::paddr_u                  miss_addr_i,
  input  icache_lce_pkg::lce_cmd_s                lce_cmd_i,
  input  logic                                    lce_cmd_v_i,
  output logic                                    lce_cmd_yumi_o,
  output icache_lce_pkg::lce_resp_s               lce_resp_o,
  output logic                                    lce_resp_v_o,
  input  logic                                    lce_resp_yumi_i,
  output icache_lce_pkg::tag_mem_pkt_s            tag_mem_pkt_o,
  output logic                                    tag_mem_pkt_v_o,
  input  logic                                    tag_mem_pkt_ready_i,
  output icache_lce_pkg::stat_mem_pkt_s           stat_mem_pkt_o,
  output logic                                    stat_mem_pkt_v_o,
  input  logic                                    stat_mem_pkt_ready_i,
  output icache_lce_pkg::data_mem_pkt_s           data_mem_pkt_o,
  output logic                                    data_mem_pkt_v_o,
  input  logic                                    data_mem_pkt_ready_i,
  output logic                                    lce_ready_o,
  output logic                                    set_tag_received_o,
  output logic                                    cce_data_received_o,
  output logic                                    cache_req_complete_o
);

  icache_lce_pkg::tag_mem_pkt_s  sweep_tag_pkt, fsm_tag_pkt;
  icache_lce_pkg::stat_mem_pkt_s sweep_stat_pkt, fsm_stat_pkt;
  logic                          sweep_tag_pkt_v, fsm_tag_pkt_v;
  logic                          sweep_stat_pkt_v, fsm_stat_pkt_v;
  logic                          sweep_done;

  lce_init_sweep sweep (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .tag_ready_i  (tag_mem_pkt_ready_i),
    .stat_ready_i (stat_mem_pkt_ready_i),
    .tag_pkt_o    (sweep_tag_pkt),
    .tag_pkt_v_o  (sweep_tag_pkt_v),
    .stat_pkt_o   (sweep_stat_pkt),
    .stat_pkt_v_o (sweep_stat_pkt_v),
    .done_o       (sweep_done)
  );

  lce_cmd_fsm cmd_fsm (
    .clk_i                (clk_i),
    .reset_i              (reset_i),
    .sweep_done_i         (sweep_done),
    .lce_id_i             (lce_id_i),
    .miss_addr_i          (miss_addr_i),
    .lce_cmd_i            (lce_cmd_i),
    .lce_cmd_v_i          (lce_cmd_v_i),
    .lce_cmd_yumi_o       (lce_cmd_yumi_o),
    .lce_resp_o           (lce_resp_o),
    .lce_resp_v_o         (lce_resp_v_o),
    .lce_resp_yumi_i      (lce_resp_yumi_i),
    .tag_pkt_o            (fsm_tag_pkt),
    .tag_pkt_v_o          (fsm_tag_pkt_v),
    .tag_ready_i          (tag_mem_pkt_ready_i),
    .stat_pkt_o           (fsm_stat_pkt),
    .stat_pkt_v_o         (fsm_stat_pkt_v),
    .stat_ready_i         (stat_mem_pkt_ready_i),
    .data_pkt_o           (data_mem_pkt_o),
    .data_pkt_v_o         (data_mem_pkt_v_o),
    .data_ready_i         (data_mem_pkt_ready_i),
    .lce_ready_o          (lce_ready_o),
    .set_tag_received_o   (set_tag_received_o),
    .cce_data_received_o  (cce_data_received_o),
    .cache_req_complete_o (cache_req_complete_o)
  );

  // sweep owns tag and stat memories until every set is cleared
  assign tag_mem_pkt_o    = sweep_done ? fsm_tag_pkt    : sweep_tag_pkt;
  assign tag_mem_pkt_v_o  = sweep_done ? fsm_tag_pkt_v  : sweep_tag_pkt_v;
  assign stat_mem_pkt_o   = sweep_done ? fsm_stat_pkt   : sweep_stat_pkt;
  assign stat_mem_pkt_v_o = sweep_done ? fsm_stat_pkt_v : sweep_stat_pkt_v;

endmodule

//--- logic/icache_lce_pkg.sv
//############################
// sizes, message types and packet formats shared by the icache LCE command side
// referenced by scoped name from the RTL and the testbench checker
//############################

package icache_lce_pkg;

  localparam int paddr_width        = 22;
  localparam int block_offset_width = 6;
  localparam int index_width        = 6;
  localparam int ptag_width         = paddr_width - index_width - block_offset_width;
  localparam int lce_sets           = 64;
  localparam int assoc              = 8;
  localparam int way_id_width       = $clog2(assoc);
  localparam int block_width        = 64;
  localparam int lce_id_width       = 2;
  localparam int cce_id_width       = 2;
  // one sync command arrives from each directory
  localparam int num_cce            = 2;

  typedef enum logic [2:0] {
    e_coh_i = 3'd0,
    e_coh_s = 3'd1,
    e_coh_e = 3'd2,
    e_coh_f = 3'd3,
    e_coh_m = 3'd4,
    e_coh_o = 3'd5
  } coh_state_e;

  // gaps in the encoding belong to command types this block does not handle
  typedef enum logic [3:0] {
    e_lce_cmd_sync           = 4'd0,
    e_lce_cmd_set_clear      = 4'd1,
    e_lce_cmd_set_tag        = 4'd4,
    e_lce_cmd_invalidate_tag = 4'd6,
    e_lce_cmd_data           = 4'd7
  } lce_cmd_type_e;

  typedef enum logic [1:0] {
    e_lce_resp_sync_ack = 2'd0,
    e_lce_resp_inv_ack  = 2'd1
  } lce_resp_type_e;

  typedef enum logic [1:0] {
    e_tag_op_set_clear  = 2'd0,
    e_tag_op_set_tag    = 2'd1,
    e_tag_op_invalidate = 2'd2
  } tag_op_e;

  typedef struct packed {
    logic [ptag_width-1:0]         tag;
    logic [index_width-1:0]        index;
    logic [block_offset_width-1:0] offset;
  } paddr_fields_s;

  // one physical address word, seen whole or split into tag, set and offset
  typedef union packed {
    logic [paddr_width-1:0] raw;
    paddr_fields_s          fields;
  } paddr_u;

  typedef struct packed {
    paddr_u                    addr;
    lce_cmd_type_e             msg_type;
    logic [way_id_width-1:0]   way_id;
    coh_state_e                state;
    logic [cce_id_width-1:0]   src_id;
    logic [block_width-1:0]    data;
  } lce_cmd_s;

  typedef struct packed {
    paddr_u                    addr;
    lce_resp_type_e            msg_type;
    logic [lce_id_width-1:0]   src_id;
    logic [cce_id_width-1:0]   dst_id;
  } lce_resp_s;

  typedef struct packed {
    logic [index_width-1:0]    index;
    logic [way_id_width-1:0]   way_id;
    coh_state_e                state;
    logic [ptag_width-1:0]     tag;
    tag_op_e                   opcode;
  } tag_mem_pkt_s;

  // stat memory only ever sees a set clear here
  typedef struct packed {
    logic [index_width-1:0]    index;
  } stat_mem_pkt_s;

  typedef struct packed {
    logic [index_width-1:0]    index;
    logic [way_id_width-1:0]   way_id;
    logic [block_width-1:0]    data;
  } data_mem_pkt_s;

endpackage

//--- logic/lce_cmd_fsm.sv
//############################
// decodes directory commands into tag, stat and data memory writes
// and answers sync and invalidate commands with responses
//############################

module lce_cmd_fsm (
  input  logic                                    clk_i,
  input  logic                                    reset_i,
  input  logic                                    sweep_done_i,
  input  logic [icache_lce_pkg::lce_id_width-1:0] lce_id_i,
  input  icache_lce_pkg::paddr_u                  miss_addr_i,
  input  icache_lce_pkg::lce_cmd_s                lce_cmd_i,
  input  logic                                    lce_cmd_v_i,
  output logic                                    lce_cmd_yumi_o,
  output icache_lce_pkg::lce_resp_s               lce_resp_o,
  output logic                                    lce_resp_v_o,
  input  logic                                    lce_resp_yumi_i,
  output icache_lce_pkg::tag_mem_pkt_s            tag_pkt_o,
  output logic                                    tag_pkt_v_o,
  input  logic                                    tag_ready_i,
  output icache_lce_pkg::stat_mem_pkt_s           stat_pkt_o,
  output logic                                    stat_pkt_v_o,
  input  logic                                    stat_ready_i,
  output icache_lce_pkg::data_mem_pkt_s           data_pkt_o,
  output logic                                    data_pkt_v_o,
  input  logic                                    data_ready_i,
  output logic                                    lce_ready_o,
  output logic                                    set_tag_received_o,
  output logic                                    cce_data_received_o,
  output logic                                    cache_req_complete_o
);

  typedef enum logic [1:0] {
    e_wait_sweep,
    e_sync_only,
    e_ready
  } fsm_state_e;

  fsm_state_e                              state_r, state_n;
  logic [icache_lce_pkg::cce_id_width-1:0] sync_cnt_r, sync_cnt_n;
  logic                                    inv_pending_r, inv_pending_n;
  logic                                    fill_go;

  // fill writes data and tag in one cycle or not at all
  assign fill_go = tag_ready_i & data_ready_i;

  always_comb begin
    state_n       = state_r;
    sync_cnt_n    = sync_cnt_r;
    inv_pending_n = inv_pending_r;

    lce_cmd_yumi_o    = 1'b0;
    lce_resp_o        = '0;
    lce_resp_o.src_id = lce_id_i;
    lce_resp_o.dst_id = lce_cmd_i.src_id;
    lce_resp_v_o      = 1'b0;

    tag_pkt_o            = '0;
    tag_pkt_o.index      = lce_cmd_i.addr.fields.index;
    tag_pkt_o.way_id     = lce_cmd_i.way_id;
    tag_pkt_v_o          = 1'b0;
    stat_pkt_o.index     = lce_cmd_i.addr.fields.index;
    stat_pkt_v_o         = 1'b0;
    data_pkt_o.index     = miss_addr_i.fields.index;
    data_pkt_o.way_id    = lce_cmd_i.way_id;
    data_pkt_o.data      = lce_cmd_i.data;
    data_pkt_v_o         = 1'b0;

    // sweep done stays high until reset, so this covers both later states
    lce_ready_o          = (state_r != e_wait_sweep) | sweep_done_i;
    set_tag_received_o   = 1'b0;
    cce_data_received_o  = 1'b0;
    cache_req_complete_o = 1'b0;

    if (state_r == e_wait_sweep && sweep_done_i) begin
      state_n = e_sync_only;
    end

    if (lce_cmd_v_i && state_r != e_wait_sweep) begin
      case (lce_cmd_i.msg_type)
        icache_lce_pkg::e_lce_cmd_sync: begin
          if (state_r == e_sync_only) begin
            lce_resp_o.msg_type = icache_lce_pkg::e_lce_resp_sync_ack;
            lce_resp_v_o        = 1'b1;
            lce_cmd_yumi_o      = lce_resp_yumi_i;
            if (lce_resp_yumi_i) begin
              if (int'(sync_cnt_r) == icache_lce_pkg::num_cce - 1) begin
                sync_cnt_n = '0;
                state_n    = e_ready;
              end else begin
                sync_cnt_n = sync_cnt_r + 1'b1;
              end
            end
          end
        end

        icache_lce_pkg::e_lce_cmd_set_clear: begin
          tag_pkt_o.way_id = '0;
          tag_pkt_o.state  = icache_lce_pkg::e_coh_i;
          tag_pkt_o.opcode = icache_lce_pkg::e_tag_op_set_clear;
          tag_pkt_v_o      = tag_ready_i & stat_ready_i;
          stat_pkt_v_o     = tag_ready_i & stat_ready_i;
          lce_cmd_yumi_o   = tag_ready_i & stat_ready_i;
        end

        icache_lce_pkg::e_lce_cmd_set_tag: begin
          if (state_r == e_ready) begin
            tag_pkt_o.state    = lce_cmd_i.state;
            tag_pkt_o.tag      = lce_cmd_i.addr.fields.tag;
            tag_pkt_o.opcode   = icache_lce_pkg::e_tag_op_set_tag;
            tag_pkt_v_o        = tag_ready_i;
            lce_cmd_yumi_o     = tag_ready_i;
            set_tag_received_o = tag_ready_i;
          end
        end

        icache_lce_pkg::e_lce_cmd_invalidate_tag: begin
          if (state_r == e_ready) begin
            tag_pkt_o.state  = icache_lce_pkg::e_coh_i;
            tag_pkt_o.opcode = icache_lce_pkg::e_tag_op_invalidate;
            // tag already invalidated, only the ack is still waiting
            tag_pkt_v_o      = tag_ready_i & ~inv_pending_r;

            lce_resp_o.msg_type = icache_lce_pkg::e_lce_resp_inv_ack;
            lce_resp_o.addr.raw = lce_cmd_i.addr.raw;
            lce_resp_v_o        = inv_pending_r | tag_pkt_v_o;
            lce_cmd_yumi_o      = lce_resp_v_o & lce_resp_yumi_i;
            inv_pending_n       = lce_resp_v_o & ~lce_resp_yumi_i;
          end
        end

        icache_lce_pkg::e_lce_cmd_data: begin
          if (state_r == e_ready) begin
            tag_pkt_o.index      = miss_addr_i.fields.index;
            tag_pkt_o.state      = lce_cmd_i.state;
            tag_pkt_o.tag        = lce_cmd_i.addr.fields.tag;
            tag_pkt_o.opcode     = icache_lce_pkg::e_tag_op_set_tag;
            tag_pkt_v_o          = fill_go;
            data_pkt_v_o         = fill_go;
            lce_cmd_yumi_o       = fill_go;
            cce_data_received_o  = fill_go;
            set_tag_received_o   = fill_go;
            cache_req_complete_o = fill_go;
          end
        end

        default: state_n = state_r;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r       <= e_wait_sweep;
      sync_cnt_r    <= '0;
      inv_pending_r <= 1'b0;
    end else begin
      state_r       <= state_n;
      sync_cnt_r    <= sync_cnt_n;
      inv_pending_r <= inv_pending_n;
    end
  end

  // the directory must hold its command until we consume it
  assert property (@(posedge clk_i) disable iff (reset_i) lce_cmd_yumi_o |-> lce_cmd_v_i);

  assert property (@(posedge clk_i) disable iff (reset_i) tag_pkt_v_o |-> tag_ready_i);

endmodule

//--- logic/lce_init_sweep.sv
//############################
// clears the tag and stat entry of every cache set once after reset
//############################

module lce_init_sweep (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          tag_ready_i,
  input  logic                          stat_ready_i,
  output icache_lce_pkg::tag_mem_pkt_s  tag_pkt_o,
  output logic                          tag_pkt_v_o,
  output icache_lce_pkg::stat_mem_pkt_s stat_pkt_o,
  output logic                          stat_pkt_v_o,
  output logic                          done_o
);

  logic [icache_lce_pkg::index_width-1:0] set_r;
  logic                                   done_r;
  logic                                   issue;
  icache_lce_pkg::paddr_u                 set_addr;

  // a set only advances when both memories take the clear together
  assign issue = ~done_r & tag_ready_i & stat_ready_i;

  always_comb begin
    set_addr.raw = {{icache_lce_pkg::ptag_width{1'b0}}, set_r,
                    {icache_lce_pkg::block_offset_width{1'b0}}};

    tag_pkt_o        = '0;
    tag_pkt_o.index  = set_addr.fields.index;
    tag_pkt_o.state  = icache_lce_pkg::e_coh_i;
    tag_pkt_o.opcode = icache_lce_pkg::e_tag_op_set_clear;
    stat_pkt_o.index = set_addr.fields.index;
  end

  assign tag_pkt_v_o  = issue;
  assign stat_pkt_v_o = issue;
  assign done_o       = done_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      set_r  <= '0;
      done_r <= 1'b0;
    end else if (issue) begin
      set_r  <= set_r + 1'b1;
      done_r <= (int'(set_r) == icache_lce_pkg::lce_sets - 1);
    end
  end

  // after the sweep the memories belong to the command FSM for good
  assert property (@(posedge clk_i) disable iff (reset_i)
    done_o |=> done_o && !tag_pkt_v_o && !stat_pkt_v_o);

endmodule

//--- run_sim.sh
#!/bin/sh
# builds the icache LCE testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module tb_icache_lce -f icache_lce.f -o sim_icache_lce
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

sim_out=$(./obj_dir/sim_icache_lce)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "Test OK"; then
  exit 0
else
  exit 1
fi

//--- testbench/icache_lce_testdata.txt
# name type addr way state src data miss | tag_v idx way state tag op stat_v
# data_v data_idx resp_v resp_type resp_addr pulses(set_tag,data_rcv,complete)
sync_a 0 000000 0 0 0 0 000000 0 00 0 0 000 0 0 0 00 1 0 000000 0
sync_b 0 000000 0 0 1 0 000000 0 00 0 0 000 0 0 0 00 1 0 000000 0
clear_a 1 2a54c0 5 2 0 0 000000 1 13 0 0 000 0 1 0 00 0 0 000000 0
settag_a 4 2a54c0 3 1 0 0 000000 1 13 3 1 2a5 1 0 0 00 0 0 000000 4
settag_b 4 1f0140 7 2 1 0 000000 1 05 7 2 1f0 1 0 0 00 0 0 000000 4
settag_c 4 155a88 1 4 0 0 000000 1 2a 1 4 155 1 0 0 00 0 0 000000 4
settag_d 4 07e800 6 3 0 0 000000 1 20 6 3 07e 1 0 0 00 0 0 000000 4
inv_a 6 2a54c0 3 0 1 0 000000 1 13 3 0 000 2 0 0 00 1 1 2a54c0 0
inv_b 6 3c1fc0 6 0 0 0 000000 1 3f 6 0 000 2 0 0 00 1 1 3c1fc0 0
inv_c 6 155a88 1 0 1 0 000000 1 2a 1 0 000 2 0 0 00 1 1 155a88 0
fill_a 7 07e800 2 1 0 0123456789abcdef 000440 1 11 2 1 07e 1 0 1 11 0 0 000000 7
fill_b 7 1f0140 4 2 0 fedcba9876543210 012e80 1 3a 4 2 1f0 1 0 1 3a 0 0 000000 7
fill_c 7 155a88 0 4 1 00000000cafe0001 000440 1 11 0 4 155 1 0 1 11 0 0 000000 7
clear_b 1 3c1fc0 0 0 0 0 000000 1 3f 0 0 000 0 1 0 00 0 0 000000 0
clear_c 1 1f0140 2 1 1 0 000000 1 05 0 0 000 0 1 0 00 0 0 000000 0
settag_e 4 000000 0 1 0 0 000000 1 00 0 1 000 1 0 0 00 0 0 000000 4

//--- testbench/lce_checker.sv
//############################
// watches the icache LCE ports and compares each accepted command
// with the expected packets and responses given by the testbench top
//############################

module lce_checker (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          cmd_yumi_i,
  input  icache_lce_pkg::lce_resp_s     resp_i,
  input  logic                          resp_v_i,
  input  logic                          resp_yumi_i,
  input  icache_lce_pkg::tag_mem_pkt_s  tag_pkt_i,
  input  logic                          tag_v_i,
  input  icache_lce_pkg::stat_mem_pkt_s stat_pkt_i,
  input  logic                          stat_v_i,
  input  icache_lce_pkg::data_mem_pkt_s data_pkt_i,
  input  logic                          data_v_i,
  input  logic                          lce_ready_i,
  input  logic                          set_tag_rcv_i,
  input  logic                          data_rcv_i,
  input  logic                          complete_i,
  input  logic                          test_active_i,
  input  logic [127:0]                  test_name_i,
  input  icache_lce_pkg::tag_mem_pkt_s  exp_tag_i,
  input  logic                          exp_tag_v_i,
  input  logic                          exp_stat_v_i,
  input  icache_lce_pkg::data_mem_pkt_s exp_data_i,
  input  logic                          exp_data_v_i,
  input  icache_lce_pkg::lce_resp_s     exp_resp_i,
  input  logic                          exp_resp_v_i,
  input  logic [2:0]                    exp_pulse_i,
  output int                            error_count_o,
  output int                            tests_done_o,
  output int                            tests_failed_o,
  output logic                          sweep_checked_o
);
  timeunit 1ns;
  timeprecision 1ns;

  int tag_clr [icache_lce_pkg::lce_sets];
  int stat_clr [icache_lce_pkg::lce_sets];
  int n_tag, n_stat, n_data, n_resp, n_st, n_dr, n_cp;
  int errs = 0;
  int done = 0;
  int failed = 0;
  logic test_bad = 1'b0;
  logic reset_q = 1'b0;
  logic sweep_checked = 1'b0;
  logic resp_pend = 1'b0;
  icache_lce_pkg::tag_mem_pkt_s  last_tag;
  icache_lce_pkg::stat_mem_pkt_s last_stat;
  icache_lce_pkg::data_mem_pkt_s last_data;
  icache_lce_pkg::lce_resp_s     last_resp;
  icache_lce_pkg::lce_resp_s     pend_resp;

  assign error_count_o   = errs;
  assign tests_done_o    = done;
  assign tests_failed_o  = failed;
  assign sweep_checked_o = sweep_checked;

  task automatic check_field(input string sig, input logic [63:0] exp, input logic [63:0] got);
    if (exp !== got) begin
      $display("MISMATCH time=%0t %s expected=%h actual=%h", $time, sig, exp, got);
      errs++;
      test_bad = 1'b1;
    end
  endtask

  task automatic report_error(input string msg);
    $display("ERROR time=%0t %s", $time, msg);
    errs++;
    test_bad = 1'b1;
  endtask

  task automatic check_count(input string what, input int seen, input logic expected);
    if (seen != int'(expected)) begin
      report_error($sformatf("%s: expected %0d, saw %0d", what, expected, seen));
    end
  endtask

  task automatic clear_counts();
    n_tag  = 0;
    n_stat = 0;
    n_data = 0;
    n_resp = 0;
    n_st   = 0;
    n_dr   = 0;
    n_cp   = 0;
  endtask

  // every set must see exactly one clear before lce_ready rises
  task automatic check_sweep();
    for (int i = 0; i < icache_lce_pkg::lce_sets; i++) begin
      if (tag_clr[i] != 1 || stat_clr[i] != 1) begin
        report_error($sformatf("sweep: set %0d saw %0d tag and %0d stat clears",
                               i, tag_clr[i], stat_clr[i]));
      end
    end
    $display("test sweep: %s", test_bad ? "FAIL" : "PASS");
    if (test_bad) failed++;
    test_bad      = 1'b0;
    sweep_checked = 1'b1;
    clear_counts();
  endtask

  task automatic finish_test();
    check_count("tag packets", n_tag, exp_tag_v_i);
    if (exp_tag_v_i && n_tag == 1) begin
      check_field("tag_mem_pkt_o.index", 64'(exp_tag_i.index), 64'(last_tag.index));
      check_field("tag_mem_pkt_o.way_id", 64'(exp_tag_i.way_id), 64'(last_tag.way_id));
      check_field("tag_mem_pkt_o.state", 64'(exp_tag_i.state), 64'(last_tag.state));
      check_field("tag_mem_pkt_o.tag", 64'(exp_tag_i.tag), 64'(last_tag.tag));
      check_field("tag_mem_pkt_o.opcode", 64'(exp_tag_i.opcode), 64'(last_tag.opcode));
    end
    check_count("stat packets", n_stat, exp_stat_v_i);
    if (exp_stat_v_i && n_stat == 1) begin
      check_field("stat_mem_pkt_o.index", 64'(exp_tag_i.index), 64'(last_stat.index));
    end
    check_count("data packets", n_data, exp_data_v_i);
    if (exp_data_v_i && n_data == 1) begin
      check_field("data_mem_pkt_o.index", 64'(exp_data_i.index), 64'(last_data.index));
      check_field("data_mem_pkt_o.way_id", 64'(exp_data_i.way_id), 64'(last_data.way_id));
      check_field("data_mem_pkt_o.data", exp_data_i.data, last_data.data);
    end
    check_count("accepted responses", n_resp, exp_resp_v_i);
    if (exp_resp_v_i && n_resp == 1) begin
      check_field("lce_resp_o.msg_type", 64'(exp_resp_i.msg_type), 64'(last_resp.msg_type));
      check_field("lce_resp_o.addr", 64'(exp_resp_i.addr.raw), 64'(last_resp.addr.raw));
      check_field("lce_resp_o.src_id", 64'(exp_resp_i.src_id), 64'(last_resp.src_id));
      check_field("lce_resp_o.dst_id", 64'(exp_resp_i.dst_id), 64'(last_resp.dst_id));
    end
    check_count("set_tag_received pulses", n_st, exp_pulse_i[2]);
    check_count("cce_data_received pulses", n_dr, exp_pulse_i[1]);
    check_count("cache_req_complete pulses", n_cp, exp_pulse_i[0]);
    done++;
    $display("test %0d %0s: %s", done, test_name_i, test_bad ? "FAIL" : "PASS");
    if (test_bad) failed++;
    test_bad = 1'b0;
    clear_counts();
  endtask

  always @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < icache_lce_pkg::lce_sets; i++) begin
        tag_clr[i]  = 0;
        stat_clr[i] = 0;
      end
      clear_counts();
      sweep_checked = 1'b0;
      test_bad      = 1'b0;
      reset_q       = 1'b1;
      resp_pend     = 1'b0;
    end else begin
      if (reset_q && (cmd_yumi_i || resp_v_i || data_v_i || lce_ready_i
                      || set_tag_rcv_i || data_rcv_i || complete_i)) begin
        report_error("an output was high in the first cycle after reset");
      end
      reset_q = 1'b0;
      // a response once offered stays put until the consumer takes it
      if (resp_pend && (!resp_v_i || resp_i !== pend_resp)) begin
        report_error("a response was dropped or changed before it was accepted");
      end
      resp_pend = resp_v_i && !resp_yumi_i;
      pend_resp = resp_i;
      if (!sweep_checked) begin
        if (tag_v_i) begin
          tag_clr[tag_pkt_i.index]++;
          check_field("tag_mem_pkt_o.opcode", 64'(icache_lce_pkg::e_tag_op_set_clear),
                      64'(tag_pkt_i.opcode));
          check_field("tag_mem_pkt_o.tag", 64'd0, 64'(tag_pkt_i.tag));
        end
        if (stat_v_i) stat_clr[stat_pkt_i.index]++;
        if (lce_ready_i) check_sweep();
      end else if (test_active_i) begin
        if (tag_v_i) begin
          n_tag++;
          last_tag = tag_pkt_i;
        end
        if (stat_v_i) begin
          n_stat++;
          last_stat = stat_pkt_i;
        end
        if (data_v_i) begin
          n_data++;
          last_data = data_pkt_i;
        end
        if (resp_v_i && resp_yumi_i) begin
          n_resp++;
          last_resp = resp_i;
        end
        if (set_tag_rcv_i) n_st++;
        if (data_rcv_i) n_dr++;
        if (complete_i) n_cp++;
        if (cmd_yumi_i) finish_test();
      end else if (cmd_yumi_i) begin
        report_error("a command was consumed while no test expected it");
      end
    end
  end

endmodule

//--- testbench/tb_icache_lce.sv
//############################
// testbench top for the icache LCE, reads commands from the test data file
// and stalls the memories and response consumer at random
//############################

module tb_icache_lce;
  timeunit 1ns;
  timeprecision 1ns;

  logic clk, reset, loaded, test_active;
  logic cmd_v, cmd_yumi, resp_v, resp_yumi, tag_v, tag_ready, stat_v, stat_ready;
  logic data_v, data_ready, lce_ready, set_tag_rcv, data_rcv, req_complete;
  icache_lce_pkg::lce_cmd_s      cmd;
  icache_lce_pkg::paddr_u        miss_addr;
  icache_lce_pkg::lce_resp_s     resp, exp_resp;
  icache_lce_pkg::tag_mem_pkt_s  tag_pkt, exp_tag;
  icache_lce_pkg::stat_mem_pkt_s stat_pkt;
  icache_lce_pkg::data_mem_pkt_s data_pkt, exp_data;
  logic exp_tag_v, exp_stat_v, exp_data_v, exp_resp_v, sweep_checked;
  logic [2:0] exp_pulse;
  logic [127:0] test_name;
  int errors, tests_done, tests_failed, stim_errors, limit;
  int seed;
  string lines[$];

  // fields of one test data line
  logic [3:0]  f_type;
  logic [21:0] f_addr, f_miss, f_raddr;
  logic [2:0]  f_way, f_state, f_tway, f_tstate, f_pulse;
  logic [1:0]  f_src, f_top, f_rtype;
  logic [63:0] f_data;
  logic [5:0]  f_tidx, f_didx;
  logic [9:0]  f_ttag;
  logic        f_tag_v, f_stat_v, f_data_v, f_resp_v;

  icache_lce UUT (
    .clk_i(clk), .reset_i(reset), .lce_id_i(2'd1), .miss_addr_i(miss_addr),
    .lce_cmd_i(cmd), .lce_cmd_v_i(cmd_v), .lce_cmd_yumi_o(cmd_yumi),
    .lce_resp_o(resp), .lce_resp_v_o(resp_v), .lce_resp_yumi_i(resp_yumi),
    .tag_mem_pkt_o(tag_pkt), .tag_mem_pkt_v_o(tag_v), .tag_mem_pkt_ready_i(tag_ready),
    .stat_mem_pkt_o(stat_pkt), .stat_mem_pkt_v_o(stat_v), .stat_mem_pkt_ready_i(stat_ready),
    .data_mem_pkt_o(data_pkt), .data_mem_pkt_v_o(data_v), .data_mem_pkt_ready_i(data_ready),
    .lce_ready_o(lce_ready), .set_tag_received_o(set_tag_rcv),
    .cce_data_received_o(data_rcv), .cache_req_complete_o(req_complete)
  );

  lce_checker check (
    .clk_i(clk), .reset_i(reset), .cmd_yumi_i(cmd_yumi),
    .resp_i(resp), .resp_v_i(resp_v), .resp_yumi_i(resp_yumi),
    .tag_pkt_i(tag_pkt), .tag_v_i(tag_v), .stat_pkt_i(stat_pkt), .stat_v_i(stat_v),
    .data_pkt_i(data_pkt), .data_v_i(data_v), .lce_ready_i(lce_ready),
    .set_tag_rcv_i(set_tag_rcv), .data_rcv_i(data_rcv), .complete_i(req_complete),
    .test_active_i(test_active), .test_name_i(test_name),
    .exp_tag_i(exp_tag), .exp_tag_v_i(exp_tag_v), .exp_stat_v_i(exp_stat_v),
    .exp_data_i(exp_data), .exp_data_v_i(exp_data_v),
    .exp_resp_i(exp_resp), .exp_resp_v_i(exp_resp_v), .exp_pulse_i(exp_pulse),
    .error_count_o(errors), .tests_done_o(tests_done),
    .tests_failed_o(tests_failed), .sweep_checked_o(sweep_checked)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic load_testdata();
    int fd;
    int c;
    string line;
    fd = $fopen("testbench/icache_lce_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open the test data file");
      stim_errors++;
    end else begin
      while (!$feof(fd)) begin
        c = $fgets(line, fd);
        if (c > 0 && line.len() > 1 && line.getc(0) != 8'h23) lines.push_back(line);
      end
      $fclose(fd);
      if (lines.size() == 0) begin
        $display("the test data file holds no test lines");
        stim_errors++;
      end
    end
  endtask

  task automatic apply_line(input string line);
    int n;
    n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                test_name, f_type, f_addr, f_way, f_state, f_src, f_data, f_miss,
                f_tag_v, f_tidx, f_tway, f_tstate, f_ttag, f_top, f_stat_v,
                f_data_v, f_didx, f_resp_v, f_rtype, f_raddr, f_pulse);
    if (n != 21) begin
      $display("test data line has %0d fields instead of 21: %s", n, line);
      stim_errors++;
    end
    cmd.addr.raw = f_addr;
    cmd.msg_type = icache_lce_pkg::lce_cmd_type_e'(f_type);
    cmd.way_id   = f_way;
    cmd.state    = icache_lce_pkg::coh_state_e'(f_state);
    cmd.src_id   = f_src;
    cmd.data     = f_data;
    miss_addr.raw = f_miss;
    exp_tag.index  = f_tidx;
    exp_tag.way_id = f_tway;
    exp_tag.state  = icache_lce_pkg::coh_state_e'(f_tstate);
    exp_tag.tag    = f_ttag;
    exp_tag.opcode = icache_lce_pkg::tag_op_e'(f_top);
    exp_data.index  = f_didx;
    exp_data.way_id = f_way;
    exp_data.data   = f_data;
    exp_resp.addr.raw = f_raddr;
    exp_resp.msg_type = icache_lce_pkg::lce_resp_type_e'(f_rtype);
    exp_resp.src_id   = 2'd1;
    exp_resp.dst_id   = f_src;
    exp_tag_v  = f_tag_v;
    exp_stat_v = f_stat_v;
    exp_data_v = f_data_v;
    exp_resp_v = f_resp_v;
    exp_pulse  = f_pulse;
  endtask

  // hold one command until the DUT consumes it
  task automatic run_test(input string line);
    apply_line(line);
    cmd_v       = 1'b1;
    test_active = 1'b1;
    @(posedge clk);
    while (!cmd_yumi) @(posedge clk);
    @(negedge clk);
    cmd_v       = 1'b0;
    test_active = 1'b0;
  endtask

  // a set_tag offered between the two syncs must stay pending
  task automatic probe_early_set_tag();
    cmd.addr.raw = 22'h2a54c0;
    cmd.msg_type = icache_lce_pkg::e_lce_cmd_set_tag;
    cmd.way_id   = 3'd1;
    cmd.state    = icache_lce_pkg::e_coh_s;
    cmd_v        = 1'b1;
    repeat (6) @(posedge clk);
    @(negedge clk);
    cmd_v = 1'b0;
  endtask

  initial begin
    int r;
    forever begin
      @(negedge clk);
      r = $random(seed);
      tag_ready  = r[1:0] != 2'd0;
      stat_ready = r[3:2] != 2'd0;
      data_ready = r[5:4] != 2'd0;
      resp_yumi  = r[6];
    end
  end

  initial begin
    wait (loaded);
    limit = 400 * lines.size() + icache_lce_pkg::lce_sets * 4;
    repeat (limit) @(posedge clk);
    $display("watchdog expired after %0d cycles", limit);
    $display("Test FAILED");
    $finish;
  end

  initial begin
    seed = 52490;
    reset = 1'b1;
    loaded = 1'b0;
    test_active = 1'b0;
    cmd_v = 1'b0;
    cmd = '0;
    miss_addr = '0;
    resp_yumi = 1'b0;
    tag_ready = 1'b0;
    stat_ready = 1'b0;
    data_ready = 1'b0;
    exp_tag = '0;
    exp_data = '0;
    exp_resp = '0;
    {exp_tag_v, exp_stat_v, exp_data_v, exp_resp_v} = '0;
    exp_pulse = '0;
    test_name = '0;
    stim_errors = 0;
    load_testdata();
    loaded = 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    while (!lce_ready) @(negedge clk);
    foreach (lines[t]) begin
      run_test(lines[t]);
      if (t == 0 && f_type == 4'd0) probe_early_set_tag();
    end
    @(negedge clk);
    $display("tests run: %0d, failed: %0d, errors: %0d",
             tests_done + 1, tests_failed, errors + stim_errors);
    if (errors == 0 && stim_errors == 0 && sweep_checked && tests_done == lines.size()) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule
